// ==== logic/cmac_mul_pkg.sv ====
/*
 * mac multiplier shared definitions
 * widths, lane layout, booth sign-extension bias and payload types
 */
`default_nettype none

package cmac_mul_pkg;

  // ========================================================================
  // widths
  // ========================================================================
  localparam int op_w        = 16;  // operand width
  localparam int lane_w      = 8;   // operand bits per lane in int8 mode
  localparam int num_lanes   = 2;
  localparam int booth_w     = 17;  // selector out, one spare bit for 2x
  localparam int pp_w        = 24;  // level-1 partial product
  localparam int res_w       = 32;  // carry-save result word
  localparam int pp_per_bank = 5;   // 4 selector rows + trailing inv row

  // ========================================================================
  // sign-extension bias
  // ========================================================================
  // each booth row has its sign bit inverted and a leading one implied,
  // the constant these leave behind is removed by the accumulator

  // four 8-bit rows, per lane
  localparam logic [op_w-1:0]  int8_bias  = 16'h5500;
  // eight 16-bit rows across the full word
  localparam logic [res_w-1:0] int16_bias = 32'h5555_0000;

  // ========================================================================
  // types
  // ========================================================================
  typedef logic [pp_w-1:0]             pp_t;          // one aligned row
  typedef pp_t  [pp_per_bank-1:0]      pp_bank_t;     // one bank of rows
  typedef logic [res_w-1:0]            res_t;
  typedef logic [2:0]                  booth_code_t;  // {b2i+1, b2i, b2i-1}

endpackage

`default_nettype wire

// ==== logic/cmac_pp_bus_if.sv ====
/*
 * partial-product bus from the booth generator
 * to the level-1 trees and the result selector
 */
`timescale 1ns/1ps
`default_nettype none

interface cmac_pp_bus_if;
  import cmac_mul_pkg::*;

  pp_bank_t               pp_lo;     // rows from a[7:0]
  pp_bank_t               pp_hi;     // rows from upper code window
  logic [num_lanes-1:0]   lane_vld;  // per-lane operand valid
  logic                   is_int8;   // registered mode

  // generator side
  modport gen (
    output pp_lo,
    output pp_hi,
    output lane_vld,
    output is_int8
  );

  // level-1 reducers only need the banks
  modport tree (
    input pp_lo,
    input pp_hi
  );

  // result select needs control only
  modport sel (
    input lane_vld,
    input is_int8
  );

endinterface

`default_nettype wire

// ==== logic/cmac_booth_sel.sv ====
/*
 * radix-4 booth selector
 * one digit to 0, +-1x or +-2x of the multiplicand, 16-bit or 8-bit form
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_booth_sel (
  input  cmac_mul_pkg::booth_code_t          code,
  input  logic                               is_8bit,
  input  logic [cmac_mul_pkg::op_w-1:0]      src_data,
  output logic [cmac_mul_pkg::booth_w-1:0]   out_data,
  output logic                               out_inv
);
  import cmac_mul_pkg::*;

  logic                 neg;    // 100, 101, 110
  logic                 dbl;    // 011 or 100
  logic                 zero;   // 000 or 111
  logic [booth_w-1:0]   m16;    // signed multiple, 16-bit form
  logic [booth_w-1:0]   v16;
  logic [lane_w:0]      m8;     // signed multiple, 8-bit form
  logic [lane_w:0]      v8;

  // ========================================================================
  // digit decode
  // ========================================================================
  always_comb begin
    neg  = code[2] & ~(code[1] & code[0]);
    dbl  = (code == 3'b011) || (code == 3'b100);
    zero = (code == 3'b000) || (code == 3'b111);
  end

  // ========================================================================
  // multiple select
  // ========================================================================
  always_comb begin
    // 2x just moves the lsb up, top bit keeps the sign
    m16 = dbl ? {src_data, 1'b0} : {src_data[op_w-1], src_data};
    m8  = dbl ? {src_data[lane_w-1:0], 1'b0} :
                {src_data[lane_w-1], src_data[lane_w-1:0]};

    // ones complement for negative digits, +1 rides on the next row
    if (zero) begin
      v16 = '0;
      v8  = '0;
    end else begin
      v16 = neg ? ~m16 : m16;
      v8  = neg ? ~m8  : m8;
    end
  end

  // ========================================================================
  // output with inverted sign bit
  // ========================================================================
  // inverting the sign turns sign extension into a constant bias,
  // so a zero digit still puts a one at the sign position
  always_comb begin
    if (is_8bit) begin
      out_data = booth_w'({~v8[lane_w], v8[lane_w-1:0]});  // upper byte clear
    end else begin
      out_data = {~v16[op_w], v16[op_w-1:0]};
    end
    out_inv = neg & ~zero;  // add-one owed by next row
  end

endmodule

`default_nettype wire

// ==== logic/cmac_pp_gen.sv ====
/*
 * booth partial-product generator
 * recodes operand a, selects eight rows of b and aligns them into two banks
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_pp_gen (
  input  logic [cmac_mul_pkg::op_w-1:0]       op_a_dat,
  input  logic [cmac_mul_pkg::op_w-1:0]       op_b_dat,
  input  logic [cmac_mul_pkg::num_lanes-1:0]  op_a_nz,
  input  logic [cmac_mul_pkg::num_lanes-1:0]  op_b_nz,
  input  logic                                op_a_pvld,
  input  logic                                op_b_pvld,
  input  logic                                is_int8,
  cmac_pp_bus_if.gen                          pp_bus
);
  import cmac_mul_pkg::*;

  logic [lane_w:0]       code_win [num_lanes];   // 9-bit recode windows
  booth_code_t           code     [num_lanes][pp_per_bank-1];
  logic [op_w-1:0]       src      [num_lanes];   // multiplicand per bank
  logic [booth_w-1:0]    sel_data [num_lanes][pp_per_bank-1];
  logic                  sel_inv  [num_lanes][pp_per_bank-1];
  pp_bank_t              bank     [num_lanes];
  logic [num_lanes-1:0]  lane_vld;

  // ========================================================================
  // recoding
  // ========================================================================
  always_comb begin
    code_win[0] = {op_a_dat[lane_w-1:0], 1'b0};
    // int8 restarts at the upper byte, int16 overlaps bit 7
    code_win[1] = is_int8 ? {op_a_dat[op_w-1:lane_w], 1'b0} :
                            op_a_dat[op_w-1:lane_w-1];
    for (int b = 0; b < num_lanes; b++) begin
      for (int r = 0; r < pp_per_bank - 1; r++) begin
        code[b][r] = code_win[b][2*r +: 3];
      end
    end
    // each int8 lane sees its own byte, zero-extended
    src[0] = is_int8 ? op_w'(op_b_dat[lane_w-1:0])    : op_b_dat;
    src[1] = is_int8 ? op_w'(op_b_dat[op_w-1:lane_w]) : op_b_dat;
  end

  for (genvar b = 0; b < num_lanes; b++) begin : g_bank
    for (genvar r = 0; r < pp_per_bank - 1; r++) begin : g_row
      cmac_booth_sel u_booth (
        .code     (code[b][r]),
        .is_8bit  (is_int8),
        .src_data (src[b]),
        .out_data (sel_data[b][r]),
        .out_inv  (sel_inv[b][r])
      );
    end
  end

  // ========================================================================
  // alignment, row r at 2r, previous inv two bits below it
  // ========================================================================
  always_comb begin
    for (int b = 0; b < num_lanes; b++) begin
      bank[b] = '0;
      for (int r = 0; r < pp_per_bank - 1; r++) begin
        bank[b][r] = pp_t'(sel_data[b][r]) << (2 * r);
      end
      for (int r = 1; r < pp_per_bank; r++) begin
        bank[b][r][2*r-2] = sel_inv[b][r-1];  // last row holds only inv
      end
    end
  end

  // lane valid, both strobes and both nz flags
  assign lane_vld = {num_lanes{op_a_pvld & op_b_pvld}} & op_a_nz & op_b_nz;

  assign pp_bus.pp_lo    = bank[0];
  assign pp_bus.pp_hi    = bank[1];
  assign pp_bus.lane_vld = lane_vld;
  assign pp_bus.is_int8  = is_int8;

  // int16 gates the whole word, so lanes must agree
  always_comb begin
    a_int16_lane_vld: assert final (is_int8 !== 1'b0 || lane_vld[0] === lane_vld[1])
      else $error("lane valids differ in int16 mode");
  end

endmodule

`default_nettype wire

// ==== logic/cmac_csa_tree.sv ====
/*
 * carry-save reducer
 * n words down to a sum/carry pair by chained 3:2 rows
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_csa_tree #(
  parameter type word_t = logic [31:0],
  parameter int  num_in = 4
) (
  input  word_t [num_in-1:0]  pp_in,
  output word_t               sum,
  output word_t               carry
);

  word_t s_acc;   // running sum vector
  word_t c_acc;   // running carry vector, already shifted
  word_t s_nxt;

  // ========================================================================
  // 3:2 rows
  // ========================================================================
  // first two inputs seed the pair, each further input adds one row
  // sum + carry stays equal to the input total mod 2^width
  always_comb begin
    s_acc = pp_in[0];
    c_acc = pp_in[1];
    for (int i = 2; i < num_in; i++) begin
      s_nxt = s_acc ^ c_acc ^ pp_in[i];                // bitwise sum
      c_acc = ((s_acc & c_acc) | (s_acc & pp_in[i]) |
               (c_acc & pp_in[i])) << 1;               // majority, up one
      s_acc = s_nxt;
    end
  end

  assign sum   = s_acc;
  assign carry = c_acc;

  // fewer than two words leaves nothing to seed the pair
  if (num_in < 2) begin : g_num_in_chk
    $fatal(1, "cmac_csa_tree: num_in must be at least 2");
  end

endmodule

`default_nettype wire

// ==== logic/cmac_res_sel.sv ====
/*
 * result select
 * level-2 reduction for int16, per-lane pick and idle-lane gating
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_res_sel (
  input  cmac_mul_pkg::pp_t   l0_sum_lo,
  input  cmac_mul_pkg::pp_t   l0_carry_lo,
  input  cmac_mul_pkg::pp_t   l0_sum_hi,
  input  cmac_mul_pkg::pp_t   l0_carry_hi,
  cmac_pp_bus_if.sel          pp_bus,
  output cmac_mul_pkg::res_t  res_a,
  output cmac_mul_pkg::res_t  res_b
);
  import cmac_mul_pkg::*;

  res_t [3:0]  l1_in;
  res_t        l1_sum;
  res_t        l1_carry;
  res_t        res_a_ori;
  res_t        res_b_ori;
  res_t        res_a_gate;

  // ========================================================================
  // level-2 tree, int16 only
  // ========================================================================
  // upper bank weighs 2^8, inputs held at zero in int8 to stop toggling
  always_comb begin
    if (pp_bus.is_int8) begin
      l1_in = '0;
    end else begin
      l1_in[3] = res_t'(l0_carry_hi) << lane_w;
      l1_in[2] = res_t'(l0_sum_hi)   << lane_w;
      l1_in[1] = res_t'(l0_carry_lo);
      l1_in[0] = res_t'(l0_sum_lo);
    end
  end

  cmac_csa_tree #(
    .word_t (res_t),
    .num_in (4)
  ) u_tree_l1n0 (
    .pp_in (l1_in),
    .sum   (l1_sum),
    .carry (l1_carry)
  );

  // ========================================================================
  // output select and gating
  // ========================================================================
  always_comb begin
    res_a_ori  = pp_bus.is_int8 ? {l0_sum_hi[op_w-1:0], l0_sum_lo[op_w-1:0]} : l1_sum;
    res_b_ori  = pp_bus.is_int8 ? {l0_carry_hi[op_w-1:0], l0_carry_lo[op_w-1:0]} :
                                  l1_carry;
    res_a_gate = pp_bus.is_int8 ? {num_lanes{int8_bias}} : int16_bias;
    for (int l = 0; l < num_lanes; l++) begin
      // idle lane reads as bias + 0, so the accumulator adds nothing
      res_a[l*op_w +: op_w] = pp_bus.lane_vld[l] ? res_a_ori[l*op_w +: op_w] :
                                                   res_a_gate[l*op_w +: op_w];
      res_b[l*op_w +: op_w] = pp_bus.lane_vld[l] ? res_b_ori[l*op_w +: op_w] : '0;
    end
  end

  // int8 bank totals stay under 2^16 so the low halves hold them whole
  always_comb begin
    a_int8_lane_fit: assert final (pp_bus.is_int8 !== 1'b1 ||
                                   (pp_t'(l0_sum_lo + l0_carry_lo) >> op_w) == '0 &&
                                   (pp_t'(l0_sum_hi + l0_carry_hi) >> op_w) == '0)
      else $error("int8 bank total exceeds lane width");
  end

endmodule

`default_nettype wire

// ==== logic/cmac_mul.sv ====
/*
 * cmac booth multiplier, int16 or dual int8
 * carry-save result, sign-extension bias removed downstream
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_mul (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  logic                                cfg_is_int8,
  input  logic                                cfg_reg_en,
  input  logic [cmac_mul_pkg::op_w-1:0]       op_a_dat,
  input  logic [cmac_mul_pkg::num_lanes-1:0]  op_a_nz,
  input  logic                                op_a_pvld,
  input  logic [cmac_mul_pkg::op_w-1:0]       op_b_dat,
  input  logic [cmac_mul_pkg::num_lanes-1:0]  op_b_nz,
  input  logic                                op_b_pvld,
  output logic [cmac_mul_pkg::res_w-1:0]      res_a,
  output logic [cmac_mul_pkg::res_w-1:0]      res_b
);
  import cmac_mul_pkg::*;

  logic  cfg_is_int8_d1;  // mode in use
  pp_t   l0_sum_lo;
  pp_t   l0_carry_lo;
  pp_t   l0_sum_hi;
  pp_t   l0_carry_hi;

  // ========================================================================
  // mode register
  // ========================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg_is_int8_d1 <= 1'b0;  // int16 out of reset
    end else if (cfg_reg_en) begin
      cfg_is_int8_d1 <= cfg_is_int8;
    end
  end

  // ========================================================================
  // datapath, all combinational
  // ========================================================================
  cmac_pp_bus_if pp_bus ();

  cmac_pp_gen u_pp_gen (
    .op_a_dat  (op_a_dat),
    .op_b_dat  (op_b_dat),
    .op_a_nz   (op_a_nz),
    .op_b_nz   (op_b_nz),
    .op_a_pvld (op_a_pvld),
    .op_b_pvld (op_b_pvld),
    .is_int8   (cfg_is_int8_d1),
    .pp_bus    (pp_bus.gen)
  );

  // level 1, one tree per bank
  cmac_csa_tree #(
    .word_t (pp_t),
    .num_in (pp_per_bank)
  ) u_tree_l0n0 (
    .pp_in (pp_bus.pp_lo),
    .sum   (l0_sum_lo),
    .carry (l0_carry_lo)
  );

  cmac_csa_tree #(
    .word_t (pp_t),
    .num_in (pp_per_bank)
  ) u_tree_l0n1 (
    .pp_in (pp_bus.pp_hi),
    .sum   (l0_sum_hi),
    .carry (l0_carry_hi)
  );

  cmac_res_sel u_res_sel (
    .l0_sum_lo   (l0_sum_lo),
    .l0_carry_lo (l0_carry_lo),
    .l0_sum_hi   (l0_sum_hi),
    .l0_carry_hi (l0_carry_hi),
    .pp_bus      (pp_bus.sel),
    .res_a       (res_a),
    .res_b       (res_b)
  );

  // load enable must be known once out of reset
  a_cfg_reg_en_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn) !$isunknown(cfg_reg_en)
  ) else $error("cfg_reg_en unknown");

endmodule

`default_nettype wire

// ==== testbench/tb_cmac_vectors.svh ====
/*
 * directed vectors for the cmac multiplier testbench
 */
`ifndef TB_CMAC_VECTORS_SVH
`define TB_CMAC_VECTORS_SVH

// columns: load, mode, a, b, a_nz, b_nz, a_pvld, b_pvld, prod
// load pulses cfg_reg_en one cycle ahead, mode is the value on cfg_is_int8
// prod is the int16 product, or {lane1, lane0} signed byte products
typedef struct packed {
  logic        load;
  logic        mode;
  logic [15:0] a;
  logic [15:0] b;
  logic [1:0]  a_nz;
  logic [1:0]  b_nz;
  logic        a_pvld;
  logic        b_pvld;
  logic [31:0] prod;
} vec_t;

localparam int num_vec = 16;

localparam vec_t vec_tab [num_vec] = '{
  // int16 straight out of reset
  '{1'b0, 1'b0, 16'h7fff, 16'hffff, 2'b11, 2'b11, 1'b1, 1'b1, 32'hffff_8001},
  '{1'b0, 1'b0, 16'h8000, 16'h8000, 2'b11, 2'b11, 1'b1, 1'b1, 32'h4000_0000},
  '{1'b0, 1'b0, 16'h1234, 16'h0010, 2'b11, 2'b11, 1'b1, 1'b1, 32'h0001_2340},
  '{1'b0, 1'b0, 16'hfffe, 16'h3000, 2'b11, 2'b11, 1'b1, 1'b1, 32'hffff_a000},
  '{1'b0, 1'b0, 16'h1111, 16'h2222, 2'b11, 2'b11, 1'b0, 1'b1, 32'h0000_0000},
  // load int8, dual lanes
  '{1'b1, 1'b1, 16'h7f80, 16'h8080, 2'b11, 2'b11, 1'b1, 1'b1, 32'hc080_4000},
  '{1'b0, 1'b1, 16'h05fd, 16'hfd07, 2'b11, 2'b11, 1'b1, 1'b1, 32'hfff1_ffeb},
  '{1'b0, 1'b1, 16'h7f7f, 16'h7f81, 2'b11, 2'b11, 1'b1, 1'b1, 32'h3f01_c0ff},
  // lane gating in int8
  '{1'b0, 1'b1, 16'h0303, 16'h0404, 2'b01, 2'b11, 1'b1, 1'b1, 32'h0000_000c},
  '{1'b0, 1'b1, 16'h0303, 16'h0404, 2'b11, 2'b10, 1'b1, 1'b1, 32'h000c_0000},
  '{1'b0, 1'b1, 16'h0303, 16'h0404, 2'b11, 2'b11, 1'b1, 1'b0, 32'h0000_0000},
  // cfg_is_int8 moves without enable, int8 held
  '{1'b0, 1'b0, 16'h0102, 16'h0304, 2'b11, 2'b11, 1'b1, 1'b1, 32'h0003_0008},
  '{1'b0, 1'b0, 16'hff02, 16'h02ff, 2'b11, 2'b11, 1'b1, 1'b1, 32'hfffe_fffe},
  // enabled load back to int16, then held against a stray int8 value
  '{1'b1, 1'b0, 16'h0102, 16'h0304, 2'b11, 2'b11, 1'b1, 1'b1, 32'h0003_0a08},
  '{1'b0, 1'b1, 16'hff02, 16'h02ff, 2'b11, 2'b11, 1'b1, 1'b1, 32'hfffd_06fe},
  '{1'b0, 1'b1, 16'h1234, 16'h5678, 2'b00, 2'b11, 1'b1, 1'b1, 32'h0000_0000}
};

`endif

// ==== testbench/tb_cmac_mul.sv ====
/*
 * cmac booth multiplier testbench
 * directed table, then random sweeps in both modes against signed products
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cmac_mul;
  import cmac_mul_pkg::*;

`include "tb_cmac_vectors.svh"

  localparam int rand_iters = 100;  // per mode
  localparam int settle_max = 5;    // 0.1 ns polls

  logic                  nvdla_core_clk;
  logic                  nvdla_core_rstn;
  logic                  cfg_is_int8;
  logic                  cfg_reg_en;
  logic [op_w-1:0]       op_a_dat;
  logic [num_lanes-1:0]  op_a_nz;
  logic                  op_a_pvld;
  logic [op_w-1:0]       op_b_dat;
  logic [num_lanes-1:0]  op_b_nz;
  logic                  op_b_pvld;
  logic [res_w-1:0]      res_a;
  logic [res_w-1:0]      res_b;

  logic  mode_int8;  // expected mode register state
  int    test_cnt;
  int    test_fail;
  int    chk_cnt;
  int    err_cnt;

  cmac_mul dut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_is_int8     (cfg_is_int8),
    .cfg_reg_en      (cfg_reg_en),
    .op_a_dat        (op_a_dat),
    .op_a_nz         (op_a_nz),
    .op_a_pvld       (op_a_pvld),
    .op_b_dat        (op_b_dat),
    .op_b_nz         (op_b_nz),
    .op_b_pvld       (op_b_pvld),
    .res_a           (res_a),
    .res_b           (res_b)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;  // 4 ns
  end

  // ==========================================================================
  // reference and helpers
  // ==========================================================================
  // plain signed multiply, per byte lane or over the full word
  function automatic logic [res_w-1:0] signed_product(input logic int8,
                                                      input logic [op_w-1:0] a,
                                                      input logic [op_w-1:0] b);
    logic signed [res_w-1:0] p16;
    logic signed [op_w-1:0]  p8;
    logic [res_w-1:0]        r;
    r = '0;
    if (int8) begin
      for (int l = 0; l < num_lanes; l++) begin
        p8 = $signed({{lane_w{a[l*lane_w+lane_w-1]}}, a[l*lane_w +: lane_w]}) *
             $signed({{lane_w{b[l*lane_w+lane_w-1]}}, b[l*lane_w +: lane_w]});
        r[l*op_w +: op_w] = p8;
      end
    end else begin
      p16 = $signed({{op_w{a[op_w-1]}}, a}) * $signed({{op_w{b[op_w-1]}}, b});
      r = p16;
    end
    return r;
  endfunction

  task automatic drive_ops(input logic [op_w-1:0] a, input logic [op_w-1:0] b,
                           input logic [1:0] a_nz, input logic [1:0] b_nz,
                           input logic a_pvld, input logic b_pvld);
    op_a_dat  = a;
    op_b_dat  = b;
    op_a_nz   = a_nz;
    op_b_nz   = b_nz;
    op_a_pvld = a_pvld;
    op_b_pvld = b_pvld;
  endtask

  // one cycle on the cfg pins, the register captures on the following edge
  task automatic write_mode(input logic load, input logic mode);
    @(posedge nvdla_core_clk);
    #1;
    cfg_is_int8 = mode;
    cfg_reg_en  = load;
    @(posedge nvdla_core_clk);
    if (load) mode_int8 = mode;
    #1;
    cfg_reg_en = 1'b0;
  endtask

  task automatic settle_outputs(output bit settled);
    int n;
    n = 0;
    while ($isunknown({res_a, res_b}) && n < settle_max) begin
      #0.1;
      n++;
    end
    settled = !$isunknown({res_a, res_b});
    if (!settled) begin
      $display("timeout: res_a/res_b still unknown at %0t after %0d polls", $time, n);
      err_cnt++;
    end
  endtask

  // bias comes off the carry-save pair, per lane or whole word
  task automatic check_outputs(input string tag, input logic [res_w-1:0] exp, output bit ok);
    logic [op_w-1:0]  lane_sum;
    logic [res_w-1:0] word_sum;
    ok = 1'b1;
    if (mode_int8) begin
      for (int l = 0; l < num_lanes; l++) begin
        lane_sum = res_a[l*op_w +: op_w] + res_b[l*op_w +: op_w] - int8_bias;
        chk_cnt++;
        if (lane_sum !== exp[l*op_w +: op_w]) begin
          $display("[ERROR] %0t %s res_a+res_b lane%0d: got %h, expected %h",
                   $time, tag, l, lane_sum, exp[l*op_w +: op_w]);
          err_cnt++;
          ok = 1'b0;
        end
      end
    end else begin
      word_sum = res_a + res_b - int16_bias;
      chk_cnt++;
      if (word_sum !== exp) begin
        $display("[ERROR] %0t %s res_a+res_b: got %h, expected %h", $time, tag, word_sum, exp);
        err_cnt++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic report_test(input string label, input bit ok);
    test_cnt++;
    if (!ok) test_fail++;
    $display("%s (%s): %s", label, mode_int8 ? "int8" : "int16", ok ? "ok" : "mismatch");
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  task automatic run_row(input int idx);
    vec_t v;
    bit   ok;
    v = vec_tab[idx];
    write_mode(v.load, v.mode);
    drive_ops(v.a, v.b, v.a_nz, v.b_nz, v.a_pvld, v.b_pvld);
    #2;  // sample a ns before the edge
    settle_outputs(ok);
    if (ok) begin
      check_outputs($sformatf("row %0d", idx), v.prod, ok);
    end
    report_test($sformatf("row %0d", idx), ok);
  endtask

  task automatic random_sweep(input logic mode);
    logic [op_w-1:0] a;
    logic [op_w-1:0] b;
    bit              ok;
    bit              all_ok;
    all_ok = 1'b1;
    write_mode(1'b1, mode);
    for (int i = 0; i < rand_iters; i++) begin
      a = op_w'($urandom);
      b = op_w'($urandom);
      @(posedge nvdla_core_clk);
      #1;
      drive_ops(a, b, 2'b11, 2'b11, 1'b1, 1'b1);
      #2;
      settle_outputs(ok);
      if (ok) begin
        check_outputs($sformatf("random %0d", i), signed_product(mode, a, b), ok);
      end
      all_ok &= ok;
    end
    report_test($sformatf("random sweep x%0d", rand_iters), all_ok);
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 8);
    void'($urandom(86634));
    nvdla_core_rstn = 1'b0;
    cfg_is_int8     = 1'b0;
    cfg_reg_en      = 1'b0;
    drive_ops('0, '0, 2'b11, 2'b11, 1'b0, 1'b0);
    mode_int8       = 1'b0;  // reset value
    test_cnt        = 0;
    test_fail       = 0;
    chk_cnt         = 0;
    err_cnt         = 0;
    repeat (3) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;

    for (int i = 0; i < num_vec; i++) begin
      run_row(i);
    end
    random_sweep(1'b1);
    random_sweep(1'b0);

    @(posedge nvdla_core_clk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (test_fail == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+testbench
logic/cmac_mul_pkg.sv
logic/cmac_pp_bus_if.sv
logic/cmac_booth_sel.sv
logic/cmac_pp_gen.sv
logic/cmac_csa_tree.sv
logic/cmac_res_sel.sv
logic/cmac_mul.sv
testbench/tb_cmac_mul.sv

// ==== Makefile ====
# Verilator build for the cmac booth multiplier

SIM      := verilator
TOP      := tb_cmac_mul
FILELIST := verilog.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass only when the testbench prints the pass line
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD)
